// ==== all.f ====
+incdir+include
src/bus_pkg.sv
src/addr_map_pkg.sv
src/write_bus_arbiter.sv
src/read_bus_arbiter.sv
src/local_regs.sv
src/board_bus_top.sv
test/board_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the board-bus hub testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f all.f \
    --top-module board_bus_tb \
    -o board_bus_sim

./obj_dir/board_bus_sim | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== src/addr_map_pkg.sv ====
// board address map codes, register offsets and reset values used by the hub decode
`default_nettype none

package addr_map_pkg;

    // space code sits in addr[15:12]
    typedef logic [3:0] space_t;

    // ------------------------------------------------------------------
    // address spaces
    // ------------------------------------------------------------------
    localparam space_t ADDR_MAIN = 4'd0;  // main board registers
    localparam space_t ADDR_HUB  = 4'd2;  // hub quadlet memory
    localparam space_t ADDR_PROM = 4'd3;  // prom space, served externally
    localparam space_t ADDR_ETH  = 4'd4;  // ethernet space, served externally
    localparam space_t ADDR_FW   = 4'd5;  // firewire space, served externally

    // ------------------------------------------------------------------
    // main-space offsets and reset values
    // ------------------------------------------------------------------
    localparam logic [3:0] REG_IPADDR = 4'd11;  // ip address register offset

    // all ones means no address assigned yet
    localparam logic [31:0] IP_RESET = 32'hffff_ffff;

endpackage

`default_nettype wire

// ==== src/board_bus_top.sv ====
// board-bus hub top, joining the write arbiter, read arbiter and local registers
`default_nettype none

module board_bus_top #(
    parameter int HUB_ADDR_BITS = 4                      // hub memory of 16 quadlets
) (
    input  logic                  sysclk,                // board clock
    input  logic                  reset,                 // sync, active high

    // ------------------------------------------------------------------
    // write bus sources
    // ------------------------------------------------------------------
    input  bus_pkg::write_bus_t   fw_write,              // firewire write bus
    input  bus_pkg::write_bus_t   eth_write,             // ethernet write bus
    input  bus_pkg::bw_write_t    bw_write,              // block writer bus
    input  logic                  eth_write_en,          // ethernet requests the bus
    input  logic                  bw_write_en,           // block writer requests the bus

    // real-time write sources
    input  bus_pkg::rt_write_t    fw_rt,                 // firewire real-time write
    input  bus_pkg::rt_write_t    eth_rt,                // ethernet real-time write

    // ------------------------------------------------------------------
    // read address sources
    // ------------------------------------------------------------------
    input  bus_pkg::reg_addr_t    fw_raddr,              // firewire read address
    input  bus_pkg::reg_addr_t    eth_raddr,             // ethernet read address
    input  logic                  eth_read_en,           // ethernet drives reg_raddr

    // data sampler
    input  logic                  sample_busy,           // sampling in progress
    input  bus_pkg::chan_t        sample_chan,           // channel being sampled
    input  logic                  fw_sample_start,       // firewire start pulse
    input  logic                  eth_sample_start,      // ethernet start pulse
    input  logic                  eth_sample_read,       // ethernet reads sample buffer
    input  bus_pkg::sample_addr_t fw_sample_raddr,       // firewire buffer address
    input  bus_pkg::sample_addr_t eth_sample_raddr,      // ethernet buffer address

    // data from the rest of the board
    input  bus_pkg::reg_data_t    reg_rdata_ext,

    // ------------------------------------------------------------------
    // hub outputs
    // ------------------------------------------------------------------
    output bus_pkg::write_bus_t   write_bus,             // selected write bus
    output bus_pkg::rt_write_t    rt_write,              // selected real-time write
    output bus_pkg::reg_addr_t    reg_raddr,             // selected read address
    output bus_pkg::reg_data_t    reg_rdata,             // routed read data
    output logic                  sample_start,          // gated start to the sampler
    output bus_pkg::sample_addr_t sample_raddr,          // selected buffer address
    output bus_pkg::reg_data_t    ip_address             // board ip address
);

    // ------------------------------------------------------------------
    // write side arbitration
    // ------------------------------------------------------------------
    write_bus_arbiter u_write_arb (
        .fw_write     (fw_write),
        .eth_write    (eth_write),
        .bw_write     (bw_write),
        .eth_write_en (eth_write_en),
        .bw_write_en  (bw_write_en),
        .fw_rt        (fw_rt),
        .eth_rt       (eth_rt),
        .write_bus    (write_bus),       // also feeds local_regs
        .rt_write     (rt_write)
    );

    // ------------------------------------------------------------------
    // read side arbitration
    // ------------------------------------------------------------------
    read_bus_arbiter u_read_arb (
        .fw_raddr         (fw_raddr),
        .eth_raddr        (eth_raddr),
        .eth_read_en      (eth_read_en),
        .sample_busy      (sample_busy),
        .sample_chan      (sample_chan),
        .fw_sample_start  (fw_sample_start),
        .eth_sample_start (eth_sample_start),
        .eth_sample_read  (eth_sample_read),
        .fw_sample_raddr  (fw_sample_raddr),
        .eth_sample_raddr (eth_sample_raddr),
        .reg_raddr        (reg_raddr),   // also feeds local_regs
        .sample_raddr     (sample_raddr),
        .sample_start     (sample_start)
    );

    // ------------------------------------------------------------------
    // hub memory, ip register and read mux
    // ------------------------------------------------------------------
    local_regs #(
        .HUB_ADDR_BITS (HUB_ADDR_BITS)
    ) u_local_regs (
        .sysclk        (sysclk),
        .reset         (reset),
        .write_bus     (write_bus),
        .reg_raddr     (reg_raddr),
        .reg_rdata_ext (reg_rdata_ext),
        .reg_rdata     (reg_rdata),
        .ip_address    (ip_address)
    );

endmodule

`default_nettype wire

// ==== src/bus_pkg.sv ====
// shared widths and write-bus structs of the board register bus, imported by every hub block
`default_nettype none

package bus_pkg;

    // ------------------------------------------------------------------
    // widths that carry a meaning on the board bus
    // ------------------------------------------------------------------
    typedef logic [15:0] reg_addr_t;     // board register address
    typedef logic [31:0] reg_data_t;     // one quadlet
    typedef logic [7:0]  bw_addr_t;      // block writer only reaches the low 256 registers
    typedef logic [3:0]  rt_addr_t;      // real-time write slot
    typedef logic [5:0]  sample_addr_t;  // index into the sample buffer
    typedef logic [3:0]  chan_t;         // sampling channel number

    // ------------------------------------------------------------------
    // write bus as seen by all register consumers
    // ------------------------------------------------------------------
    typedef struct packed {
        logic      reg_wen;     // quadlet write strobe
        logic      blk_wen;     // block write strobe
        logic      blk_wstart;  // first word of a block write
        reg_addr_t waddr;       // full write address
        reg_data_t wdata;       // write data
    } write_bus_t;              // 51 bits

    // block writer drives the same fields with a short address
    typedef struct packed {
        logic      reg_wen;
        logic      blk_wen;
        logic      blk_wstart;
        bw_addr_t  waddr;       // zero-extended by the arbiter
        reg_data_t wdata;
    } bw_write_t;               // 43 bits

    // real-time write port, separate from the register bus
    typedef struct packed {
        logic      wen;         // real-time write strobe
        rt_addr_t  waddr;       // slot number
        reg_data_t wdata;       // slot data
    } rt_write_t;               // 37 bits

endpackage

`default_nettype wire

// ==== src/local_regs.sv ====
// hub quadlet memory, ip address register and read-data routing by address space
`default_nettype none

module local_regs #(
    parameter int HUB_ADDR_BITS = 4               // log2 of hub memory depth
) (
    input  logic                sysclk,           // board clock
    input  logic                reset,            // sync, active high

    // write and read buses
    input  bus_pkg::write_bus_t write_bus,        // arbitrated write bus
    input  bus_pkg::reg_addr_t  reg_raddr,        // arbitrated read address
    input  bus_pkg::reg_data_t  reg_rdata_ext,    // data from the remaining board registers

    // outputs
    output bus_pkg::reg_data_t  reg_rdata,        // routed read data
    output bus_pkg::reg_data_t  ip_address        // current ip address
);

    import bus_pkg::*;
    import addr_map_pkg::*;

    localparam int HUB_WORDS = 2 ** HUB_ADDR_BITS;  // quadlets in the hub memory
    localparam reg_addr_t IP_FULL_ADDR = {ADDR_MAIN, 8'h0, REG_IPADDR};  // complete ip address

    reg_data_t hub_mem [HUB_WORDS];           // hub quadlet storage
    reg_data_t ip_reg;                        // ip address storage

    space_t                   wspace;         // space of the write address
    space_t                   rspace;         // space of the read address
    logic [HUB_ADDR_BITS-1:0] hub_waddr;      // word index for writes
    logic [HUB_ADDR_BITS-1:0] hub_raddr;      // word index for reads
    logic                     hub_wen;        // write hits hub space
    logic                     ip_wen;         // write hits the ip register
    logic                     ip_rsel;        // read hits the ip register

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------
    assign wspace       = write_bus.waddr[15:12];
    assign rspace       = reg_raddr[15:12];
    assign hub_waddr    = write_bus.waddr[HUB_ADDR_BITS-1:0];
    assign hub_raddr    = reg_raddr[HUB_ADDR_BITS-1:0];

    assign hub_wen = write_bus.reg_wen && (wspace == ADDR_HUB);        // any word in hub space
    assign ip_wen  = write_bus.reg_wen && (write_bus.waddr == IP_FULL_ADDR);  // exact match
    assign ip_rsel = (reg_raddr[11:0] == IP_FULL_ADDR[11:0]);          // offset within main

    // ------------------------------------------------------------------
    // hub memory
    // ------------------------------------------------------------------
    // upper address bits inside hub space alias onto the same words
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < HUB_WORDS; i++) begin
                hub_mem[i] <= '0;                  // all words start cleared
            end
        end else if (hub_wen) begin
            hub_mem[hub_waddr] <= write_bus.wdata;
        end
    end

    // ------------------------------------------------------------------
    // ip address register
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            ip_reg <= IP_RESET;                    // unassigned after reset
        end else if (ip_wen) begin
            ip_reg <= write_bus.wdata;
        end
    end

    assign ip_address = ip_reg;

    // ------------------------------------------------------------------
    // read data routing
    // ------------------------------------------------------------------
    // prom, ethernet and firewire spaces are served off-hub
    always_comb begin
        unique case (rspace)
            ADDR_HUB: begin
                reg_rdata = hub_mem[hub_raddr];    // local hub word
            end
            ADDR_MAIN: begin
                reg_rdata = ip_rsel ? ip_reg : reg_rdata_ext;  // only the ip offset is local
            end
            default: begin
                reg_rdata = reg_rdata_ext;         // every other space
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/read_bus_arbiter.sv ====
// picks the register read address and sample-buffer address, and gates sampling start
`default_nettype none

module read_bus_arbiter (
    // register read address sources
    input  bus_pkg::reg_addr_t    fw_raddr,         // firewire read address
    input  bus_pkg::reg_addr_t    eth_raddr,        // ethernet read address
    input  logic                  eth_read_en,      // ethernet owns the read address

    // data sampler
    input  logic                  sample_busy,      // sampler owns the read address
    input  bus_pkg::chan_t        sample_chan,      // channel being sampled
    input  logic                  fw_sample_start,  // start pulse from firewire
    input  logic                  eth_sample_start, // start pulse from ethernet

    // sample buffer read address sources
    input  logic                  eth_sample_read,  // ethernet reads the sample buffer
    input  bus_pkg::sample_addr_t fw_sample_raddr,  // firewire buffer address
    input  bus_pkg::sample_addr_t eth_sample_raddr, // ethernet buffer address

    // selected values
    output bus_pkg::reg_addr_t    reg_raddr,        // shared register read address
    output bus_pkg::sample_addr_t sample_raddr,     // shared buffer read address
    output logic                  sample_start      // start pulse to the sampler
);

    import bus_pkg::*;
    import addr_map_pkg::*;

    reg_addr_t sample_status_addr;  // channel status register the sampler reads
    logic      start_req;           // either host asks to sample

    // ------------------------------------------------------------------
    // sampler address
    // ------------------------------------------------------------------
    // main space, channel number in bits 7:4
    assign sample_status_addr = {ADDR_MAIN, 4'd0, sample_chan, 4'd0};

    // ------------------------------------------------------------------
    // read address priority
    // ------------------------------------------------------------------
    always_comb begin
        if (sample_busy) begin
            reg_raddr = sample_status_addr;  // sampler holds the bus while busy
        end else if (eth_read_en) begin
            reg_raddr = eth_raddr;
        end else begin
            reg_raddr = fw_raddr;            // idle default
        end
    end

    // ------------------------------------------------------------------
    // sample buffer access
    // ------------------------------------------------------------------
    assign sample_raddr = eth_sample_read ? eth_sample_raddr : fw_sample_raddr;

    // hosts are not expected to sample at the same time, so a plain OR is enough
    assign start_req    = fw_sample_start | eth_sample_start;
    assign sample_start = start_req & ~sample_busy;  // no restart mid-sample

endmodule

`default_nettype wire

// ==== src/write_bus_arbiter.sv ====
// picks the source of the board write bus and of the real-time write port
`default_nettype none

module write_bus_arbiter (
    // write bus sources
    input  bus_pkg::write_bus_t fw_write,     // firewire host path
    input  bus_pkg::write_bus_t eth_write,    // ethernet host path
    input  bus_pkg::bw_write_t  bw_write,     // real-time block writer
    input  logic                eth_write_en, // ethernet owns the write bus
    input  logic                bw_write_en,  // block writer owns the write bus

    // real-time write sources
    input  bus_pkg::rt_write_t  fw_rt,        // firewire real-time write
    input  bus_pkg::rt_write_t  eth_rt,       // ethernet real-time write

    // selected buses
    output bus_pkg::write_bus_t write_bus,    // to all register consumers
    output bus_pkg::rt_write_t  rt_write      // to the real-time write target
);

    import bus_pkg::*;

    write_bus_t bw_wide;  // block writer lifted to the full bus format

    // ------------------------------------------------------------------
    // block writer address widening
    // ------------------------------------------------------------------
    always_comb begin
        bw_wide.reg_wen    = bw_write.reg_wen;
        bw_wide.blk_wen    = bw_write.blk_wen;
        bw_wide.blk_wstart = bw_write.blk_wstart;
        bw_wide.waddr      = reg_addr_t'(bw_write.waddr);  // upper byte zero
        bw_wide.wdata      = bw_write.wdata;
    end

    // ------------------------------------------------------------------
    // write bus priority
    // ------------------------------------------------------------------
    // whole structs move together so strobes never pair with foreign data
    always_comb begin
        if (bw_write_en) begin
            write_bus = bw_wide;        // real-time block write first
        end else if (eth_write_en) begin
            write_bus = eth_write;      // then ethernet
        end else begin
            write_bus = fw_write;       // firewire by default
        end
    end

    // ------------------------------------------------------------------
    // real-time write priority
    // ------------------------------------------------------------------
    // an active ethernet strobe claims the port, otherwise firewire drives it
    always_comb begin
        if (eth_rt.wen) begin
            rt_write = eth_rt;
        end else begin
            rt_write = fw_rt;
        end
    end

endmodule

`default_nettype wire

// ==== include/board_bus_tests.svh ====
// directed tests of the board-bus hub, included inside the testbench module body
`ifndef BOARD_BUS_TESTS_SVH
`define BOARD_BUS_TESTS_SVH

    // ------------------------------------------------------------------
    // stimulus and model helpers
    // ------------------------------------------------------------------
    task automatic idle_inputs();                             // quiet sources, firewire default
        fw_write         = '0;
        eth_write        = '0;
        bw_write         = '0;
        eth_write_en     = 1'b0;
        bw_write_en      = 1'b0;
        fw_rt            = '0;
        eth_rt           = '0;
        fw_raddr         = '0;
        eth_raddr        = '0;
        eth_read_en      = 1'b0;
        sample_busy      = 1'b0;
        sample_chan      = '0;
        fw_sample_start  = 1'b0;
        eth_sample_start = 1'b0;
        eth_sample_read  = 1'b0;
        fw_sample_raddr  = '0;
        eth_sample_raddr = '0;
        reg_rdata_ext    = '0;
    endtask

    task automatic rand_wide(input int n, output logic [63:0] v);  // n is above 32
        logic [31:0] hi;
        logic [31:0] lo;
        take_bits(n - 32, hi);
        take_bits(32, lo);
        v = {hi, lo};
    endtask

    task automatic model_write(input write_bus_t w);          // effect of one write edge
        if (w.reg_wen && w.waddr[15:12] == ADDR_HUB) begin
            hub_model[w.waddr[HUB_ADDR_BITS-1:0]] = w.wdata;  // upper bits alias
        end
        if (w.reg_wen && w.waddr == {ADDR_MAIN, 8'h00, REG_IPADDR}) begin
            ip_model = w.wdata;
        end
    endtask

    task automatic read_hub(input logic [HUB_ADDR_BITS-1:0] idx);  // read one word via firewire
        advance();
        idle_inputs();
        fw_raddr = {ADDR_HUB, 12'(idx)};
        settle();
        check_data("reg_rdata", hub_model[idx], reg_rdata);
        check_data("ip_address", ip_model, ip_address);
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    task automatic reset_values();
        hub_model = '{default: '0};                           // all words cleared by reset
        ip_model  = IP_RESET;
        for (int i = 0; i < 2**HUB_ADDR_BITS; i++) begin
            read_hub(i[HUB_ADDR_BITS-1:0]);
        end
    endtask

    task automatic write_priority();
        logic [63:0] v;
        write_bus_t  exp_bus;
        rt_write_t   exp_rt;
        for (int n = 0; n < 32; n++) begin
            advance();
            rand_wide(51, v);
            fw_write = v[50:0];
            rand_wide(51, v);
            eth_write = v[50:0];
            rand_wide(43, v);
            bw_write = v[42:0];
            rand_wide(37, v);
            fw_rt = v[36:0];
            rand_wide(37, v);
            eth_rt = v[36:0];
            eth_rt.wen = n[2];                                // both rt owners in turn
            {bw_write_en, eth_write_en} = n[1:0];             // all four enable pairs
            if (bw_write_en) begin
                exp_bus = {bw_write.reg_wen, bw_write.blk_wen, bw_write.blk_wstart,
                           8'h00, bw_write.waddr, bw_write.wdata};
            end else if (eth_write_en) begin
                exp_bus = eth_write;
            end else begin
                exp_bus = fw_write;
            end
            exp_rt = eth_rt.wen ? eth_rt : fw_rt;
            settle();
            check_write("write_bus", exp_bus, write_bus);
            check_rt("rt_write", exp_rt, rt_write);
            model_write(exp_bus);                             // random strobes may hit the hub
        end
    endtask

    task automatic read_priority();
        logic [31:0] v;
        reg_addr_t   exp_addr;
        for (int n = 0; n < 16; n++) begin
            advance();
            take_bits(32, v);
            fw_raddr  = v[15:0];
            eth_raddr = v[31:16];
            take_bits(16, v);
            sample_chan      = v[3:0];
            fw_sample_raddr  = v[9:4];
            eth_sample_raddr = v[15:10];
            {eth_sample_read, eth_read_en, sample_busy} = n[2:0];
            if (sample_busy) begin
                exp_addr = {ADDR_MAIN, 4'h0, sample_chan, 4'h0};  // channel status register
            end else if (eth_read_en) begin
                exp_addr = eth_raddr;
            end else begin
                exp_addr = fw_raddr;
            end
            settle();
            check_addr("reg_raddr", exp_addr, reg_raddr);
            check_sample_addr("sample_raddr",
                              n[2] ? eth_sample_raddr : fw_sample_raddr, sample_raddr);
        end
    endtask

    task automatic sample_gating();
        for (int n = 0; n < 8; n++) begin
            advance();
            idle_inputs();
            {sample_busy, eth_sample_start, fw_sample_start} = n[2:0];
            settle();
            check_bit("sample_start", (n[2] == 0) && (n[1:0] != 0),  // any start while idle
                      sample_start);
        end
    endtask

    task automatic hub_access();
        space_t      other_spaces [4] = '{ADDR_PROM, ADDR_ETH, ADDR_FW, 4'hf};
        logic [31:0] v;
        logic [31:0] d;
        write_bus_t  w;
        for (int n = 0; n < 12; n++) begin
            advance();
            idle_inputs();
            take_bits(12, v);
            take_bits(32, d);
            w = {3'b100, ADDR_HUB, v[11:0], d};
            eth_write_en = n[0];                              // firewire and ethernet in turn
            if (n[0]) begin
                eth_write = w;
            end else begin
                fw_write = w;
            end
            settle();
            check_write("write_bus", w, write_bus);
            model_write(w);
            read_hub(v[HUB_ADDR_BITS-1:0]);                   // visible one cycle later
        end
        for (int n = 0; n < 4; n++) begin
            advance();
            idle_inputs();
            take_bits(12, v);
            take_bits(32, d);
            fw_write = {3'b100, other_spaces[n[1:0]], v[11:0], d};  // must not touch the hub
            settle();
        end
        for (int i = 0; i < 2**HUB_ADDR_BITS; i++) begin
            read_hub(i[HUB_ADDR_BITS-1:0]);
        end
        for (int n = 0; n < 2; n++) begin
            advance();
            idle_inputs();
            take_bits(32, d);
            w = {3'b100, ADDR_MAIN, 8'h00, REG_IPADDR, d};
            if (n == 0) begin
                bw_write_en = 1'b1;
                bw_write    = {3'b100, 4'h0, REG_IPADDR, d};  // short block writer address
            end else begin
                eth_write_en = 1'b1;
                eth_write    = w;
            end
            settle();
            check_write("write_bus", w, write_bus);
            check_data("ip_address", ip_model, ip_address);   // old value until the edge
            model_write(w);
            advance();
            idle_inputs();
            settle();
            check_data("ip_address", ip_model, ip_address);
        end
    endtask

    task automatic read_routing();
        space_t      ext_spaces [4] = '{ADDR_PROM, ADDR_ETH, ADDR_FW, 4'h9};
        logic [31:0] v;
        logic [11:0] off;
        for (int n = 0; n < 12; n++) begin
            advance();
            idle_inputs();
            take_bits(32, v);
            reg_rdata_ext = v;
            take_bits(12, v);
            if (n < 8) begin
                fw_raddr = {ext_spaces[n[1:0]], v[11:0]};     // spaces served off-hub
            end else begin
                off = {4'h0, v[7:0]};
                if (n[0]) begin
                    off = {v[11:9], 1'b1, 4'h0, REG_IPADDR};  // ip low byte, nonzero upper nibble
                end else if (off == {8'h00, REG_IPADDR}) begin
                    off = 12'h000;
                end
                eth_read_en = 1'b1;
                eth_raddr   = {ADDR_MAIN, off};
            end
            settle();
            check_data("reg_rdata", reg_rdata_ext, reg_rdata);
        end
        advance();
        idle_inputs();
        take_bits(32, v);
        reg_rdata_ext = v;
        fw_raddr      = {ADDR_MAIN, 8'h00, REG_IPADDR};
        settle();
        check_data("reg_rdata", ip_model, reg_rdata);
    endtask

`endif

// ==== test/board_bus_tb.sv ====
// testbench top for the board-bus hub, runs the directed tests from the included test file
`default_nettype none

module board_bus_tb;

    import bus_pkg::*;
    import addr_map_pkg::*;

    localparam int HUB_ADDR_BITS = 4;
    localparam int CLK_PERIOD    = 4;
    // reset, reset values, write priority, read priority, start gating, hub access, routing
    localparam int TEST_CYCLES   = 10 + 16 + 32 + 16 + 8 + 48 + 13;
    localparam int MARGIN_CYCLES = 100;                      // slack for the watchdog

    logic         sysclk = 1'b0;
    logic         reset;
    write_bus_t   fw_write, eth_write;
    bw_write_t    bw_write;
    logic         eth_write_en, bw_write_en;
    rt_write_t    fw_rt, eth_rt;
    reg_addr_t    fw_raddr, eth_raddr;
    logic         eth_read_en, sample_busy;
    chan_t        sample_chan;
    logic         fw_sample_start, eth_sample_start, eth_sample_read;
    sample_addr_t fw_sample_raddr, eth_sample_raddr;
    reg_data_t    reg_rdata_ext;
    write_bus_t   write_bus;                                 // DUT outputs from here
    rt_write_t    rt_write;
    reg_addr_t    reg_raddr;
    reg_data_t    reg_rdata, ip_address;
    logic         sample_start;
    sample_addr_t sample_raddr;

    logic [31:0]  lfsr_state = 32'hbbab0b72;                 // random source state
    reg_data_t    hub_model [2**HUB_ADDR_BITS];              // expected hub words
    reg_data_t    ip_model;                                  // expected ip register

    board_bus_top #(.HUB_ADDR_BITS(HUB_ADDR_BITS)) u_dut (.*);

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    // ------------------------------------------------------------------
    // random bits, timing and error helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};      // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);              // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic advance();                                 // 1 unit after the edge
        @(posedge sysclk);
        #1;
    endtask

    task automatic settle();                                  // 1 unit before the edge
        #(CLK_PERIOD - 2);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic check_sample_addr(input string name, input sample_addr_t exp,
                                     input sample_addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic check_write(input string name, input write_bus_t exp, input write_bus_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic check_rt(input string name, input rt_write_t exp, input rt_write_t act);
        if (act !== exp) begin
            abort_run($sformatf("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Fail time=%0t %s expected=%b actual=%b", $time, name, exp, act));
        end
    endtask

    `include "board_bus_tests.svh"

    // ------------------------------------------------------------------
    // test sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        idle_inputs();
        reset = 1'b1;
        repeat (10) @(posedge sysclk);                       // 10 reset cycles
        #1;
        reset = 1'b0;
        reset_values();
        write_priority();
        read_priority();
        sample_gating();
        hub_access();
        read_routing();
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        abort_run("timeout: the tests did not finish within the expected number of cycles");
    end

endmodule

`default_nettype wire
